//--- addrDecode/addrDecode.sv
`timescale 1ns/1ps

`include "subCpu_settings.svh"

module addrDecode import subBusPkg::*; (
	input  logic     accessEn,
	input  subAddr_t reqAddr,
	input  logic     reqWrite,
	output logic     nScr0,
	output logic     nScr1,
	output logic     nObj,
	output logic     nSnd,
	output logic     nSPgm,
	output logic     nMPgm,
	output logic     nBufEn,
	output region_t  region,
	output logic     kick,
	output logic     irqAck
);

	// Fixed I/O locations
	localparam subAddr_t wdogAddr = `ADDR_WDOG;
	localparam subAddr_t ackAddr = `ADDR_IRQACK;
	localparam subAddr_t tBankAddr = `ADDR_TBANK;

	// One 1K page for each latch window
	localparam logic [5:0] lth0Page = 6'b100100;
	localparam logic [5:0] lth1Page = 6'b100101;
	localparam logic [5:0] lth2Page = 6'b101000;

	logic [5:0] page;
	region_t    mapped;

	// Only A15..A10 take part in the map
	assign page = reqAddr[15:10];

	////////////////////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		mapped = none;
		if (!page[5]) begin
			// Lower half in 8K windows
			case (page[4:3])
				2'b00: mapped = reqWrite ? scr0 : none;
				2'b01: mapped = reqWrite ? scr1 : none;
				2'b10: begin
					// Sound share RAM wins over sprite RAM
					if (page[2:0] == 3'b000) begin
						mapped = snd;
					end else if (reqWrite) begin
						mapped = obj;
					end
				end
				default: mapped = reqWrite ? none : sPgm;
			endcase
		end else if (!reqWrite) begin
			// Whole upper half reads the main program ROM
			mapped = mPgm;
		end else begin
			// I/O and latches sit under the ROM on writes
			case (page)
				wdogAddr[15:10]:  mapped = wdog;
				ackAddr[15:10]:   mapped = subBusPkg::irqAck;
				tBankAddr[15:10]: mapped = subBusPkg::tileBank;
				lth0Page:         mapped = lth0;
				lth1Page:         mapped = lth1;
				lth2Page:         mapped = lth2;
				default:          mapped = none;
			endcase
		end
	end

	// Nothing selected outside an accepted access
	assign region = accessEn ? mapped : none;

	////////////////////////////////////////////////////////////////////////////
	// Chip selects and strobes
	////////////////////////////////////////////////////////////////////////////

	assign nScr0 = region != scr0;
	assign nScr1 = region != scr1;
	assign nObj = region != obj;
	assign nSnd = region != snd;
	assign nSPgm = region != sPgm;
	assign nMPgm = region != mPgm;

	// Data buffer opens for the RAMs and the scroll latches
	assign nBufEn = !(region inside {scr0, scr1, obj, snd, lth0, lth1});

	// Strobes to the sequencer
	assign kick = region == wdog;
	assign irqAck = region == subBusPkg::irqAck;

endmodule

//--- build.f
+incdir+common
+incdir+tb
common/subBusPkg.sv
common/sysCtlPkg.sv
addrDecode/addrDecode.sv
logic/watchdogTimer.sv
logic/busSequencer.sv
logic/videoLatches.sv
logic/subCpuCtl.sv
tb/subCpuCtlTb.sv

//--- common/subBusPkg.sv
package subBusPkg;

	////////////////////////////////////////////////////////////////////////////
	// Secondary CPU bus types
	////////////////////////////////////////////////////////////////////////////

	// Full CPU address
	typedef logic [15:0] subAddr_t;

	// Write data byte
	typedef logic [7:0] subData_t;

	// Six scroll or priority bytes of one latch group
	// Byte 0 sits in the low bits
	typedef logic [47:0] scrollSet_t;

	// Decoded target of one accepted access
	typedef enum logic [3:0] {
		none,
		scr0,      // Video RAM 1
		scr1,      // Video RAM 2
		obj,       // Sprite RAM
		snd,       // Sound share RAM
		sPgm,      // Sub program ROM
		mPgm,      // Main program ROM
		wdog,      // Watchdog kick
		irqAck,    // Interrupt acknowledge
		tileBank,  // Tile bank select
		lth0,      // Scroll group 0 and ROM bank 0
		lth1,      // Scroll group 1 and ROM bank 1
		lth2       // Background colour
	} region_t;

endpackage

//--- common/subCpu_settings.svh
`ifndef SUBCPU_SETTINGS_SVH
`define SUBCPU_SETTINGS_SVH

// Frames without a kick until the watchdog fires
`define WDOG_LIMIT 10

// Frames the CPU reset stays asserted
`define RESET_HOLD 4

// Fixed write-only I/O locations
// Matched on the upper six address bits
`define ADDR_WDOG   16'h8000
`define ADDR_IRQACK 16'h8400
`define ADDR_TBANK  16'h8800

`endif

//--- common/sysCtlPkg.sv
package sysCtlPkg;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer and watchdog types
	////////////////////////////////////////////////////////////////////////////

	// Run normally or hold the CPU in reset
	typedef enum logic {
		sRun,
		sHold
	} seqState_t;

	// Frame count of the watchdog
	// Wide enough for the limit and the hold length
	typedef logic [3:0] wdCount_t;

endpackage

//--- logic/busSequencer.sv
`timescale 1ns/1ps

module busSequencer import sysCtlPkg::*; (
	input  logic nVBLK,
	input  logic rstN,
	input  logic reqValid,
	output logic reqReady,
	output logic accessEn,
	input  logic kick,
	input  logic irqAck,
	input  logic expired,
	input  logic holdDone,
	output logic restart,
	output logic running,
	output logic clearLatches,
	output logic nRes,
	output logic nIrq
);

	seqState_t state;
	seqState_t nextState;

	////////////////////////////////////////////////////////////////////////////
	// Run and hold sequencing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			sRun: begin
				// Expiry wins over a kick in the same frame
				if (expired) begin
					nextState = sHold;
				end
			end
			sHold: begin
				if (holdDone) begin
					nextState = sRun;
				end
			end
			default: nextState = sRun;
		endcase
	end

	assign running = state == sRun;

	// Bus stalls while the CPU is held in reset
	assign reqReady = running;
	assign accessEn = reqValid && reqReady;

	// Timer starts over on a kick or any phase change
	assign restart = kick || (nextState != state);

	// Latches wiped on the way into the hold
	assign clearLatches = running && expired;

	always_ff @(posedge nVBLK or negedge rstN) begin
		if (!rstN) begin
			state <= sRun;
			nRes <= 1'b1;
			nIrq <= 1'b1;
		end else begin
			state <= nextState;
			// Reset line follows the coming phase
			nRes <= nextState == sRun;
			// Frame interrupt every cycle
			// An acknowledge leaves one frame free
			if (state == sRun) begin
				nIrq <= irqAck;
			end else begin
				nIrq <= 1'b1;
			end
		end
	end

endmodule

//--- logic/subCpuCtl.sv
`timescale 1ns/1ps

module subCpuCtl import subBusPkg::*; (
	input  logic       nVBLK,
	input  logic       rstN,
	input  logic       reqValid,
	input  subAddr_t   reqAddr,
	input  logic       reqWrite,
	input  subData_t   reqData,
	output logic       reqReady,
	output logic       nScr0,
	output logic       nScr1,
	output logic       nObj,
	output logic       nSnd,
	output logic       nSPgm,
	output logic       nMPgm,
	output logic       nBufEn,
	output logic       nRes,
	output logic       nIrq,
	output scrollSet_t scroll0,
	output scrollSet_t scroll1,
	output subData_t   romBank0,
	output subData_t   romBank1,
	output logic       tileBank,
	output subData_t   backColor
);

	// Access qualification
	logic    accessEn;
	region_t region;

	// Decoder strobes
	logic kick;
	logic ackWrite;

	// Watchdog handshake
	logic expired;
	logic holdDone;
	logic restart;
	logic running;
	logic clearLatches;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	addrDecode i_addrDecode (
		.accessEn (accessEn),
		.reqAddr  (reqAddr),
		.reqWrite (reqWrite),
		.nScr0    (nScr0),
		.nScr1    (nScr1),
		.nObj     (nObj),
		.nSnd     (nSnd),
		.nSPgm    (nSPgm),
		.nMPgm    (nMPgm),
		.nBufEn   (nBufEn),
		.region   (region),
		.kick     (kick),
		.irqAck   (ackWrite)
	);

	////////////////////////////////////////////////////////////////////////////
	// Watchdog and sequencing
	////////////////////////////////////////////////////////////////////////////

	watchdogTimer i_watchdogTimer (
		.nVBLK    (nVBLK),
		.rstN     (rstN),
		.restart  (restart),
		.running  (running),
		.expired  (expired),
		.holdDone (holdDone)
	);

	busSequencer i_busSequencer (
		.nVBLK        (nVBLK),
		.rstN         (rstN),
		.reqValid     (reqValid),
		.reqReady     (reqReady),
		.accessEn     (accessEn),
		.kick         (kick),
		.irqAck       (ackWrite),
		.expired      (expired),
		.holdDone     (holdDone),
		.restart      (restart),
		.running      (running),
		.clearLatches (clearLatches),
		.nRes         (nRes),
		.nIrq         (nIrq)
	);

	// Low three address bits pick the byte inside a group
	videoLatches i_videoLatches (
		.nVBLK        (nVBLK),
		.rstN         (rstN),
		.region       (region),
		.offset       (reqAddr[2:0]),
		.wrData       (reqData),
		.clearLatches (clearLatches),
		.scroll0      (scroll0),
		.scroll1      (scroll1),
		.romBank0     (romBank0),
		.romBank1     (romBank1),
		.backColor    (backColor),
		.tileBank     (tileBank)
	);

endmodule

//--- logic/videoLatches.sv
`timescale 1ns/1ps

module videoLatches import subBusPkg::*; (
	input  logic       nVBLK,
	input  logic       rstN,
	input  region_t    region,
	input  logic [2:0] offset,
	input  subData_t   wrData,
	input  logic       clearLatches,
	output scrollSet_t scroll0,
	output scrollSet_t scroll1,
	output subData_t   romBank0,
	output subData_t   romBank1,
	output subData_t   backColor,
	output logic       tileBank
);

	// Offset of the ROM bank byte inside a group
	localparam logic [2:0] bankSlot = 3'd3;

	// Offset that no latch answers to
	localparam logic [2:0] deadSlot = 3'd7;

	////////////////////////////////////////////////////////////////////////////
	// Scroll byte placement
	////////////////////////////////////////////////////////////////////////////

	// Drops one byte into its scroll slot
	// Offsets 4..6 close the gap left by the bank byte
	function automatic scrollSet_t putScroll(
		input scrollSet_t cur,
		input logic [2:0] off,
		input subData_t   data
	);
		scrollSet_t next;
		logic [2:0] slot;
		next = cur;
		slot = (off < bankSlot) ? off : off - 3'd1;
		if (off != bankSlot && off != deadSlot) begin
			next[slot*8 +: 8] = data;
		end
		return next;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Latch registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge nVBLK or negedge rstN) begin
		if (!rstN) begin
			scroll0 <= '0;
			scroll1 <= '0;
			romBank0 <= '0;
			romBank1 <= '0;
			backColor <= '0;
			tileBank <= 1'b0;
		end else if (clearLatches) begin
			// Watchdog reset wipes the video setup
			scroll0 <= '0;
			scroll1 <= '0;
			romBank0 <= '0;
			romBank1 <= '0;
			backColor <= '0;
			tileBank <= 1'b0;
		end else begin
			case (region)
				lth0: begin
					if (offset == bankSlot) begin
						romBank0 <= wrData;
					end else begin
						scroll0 <= putScroll(scroll0, offset, wrData);
					end
				end
				lth1: begin
					if (offset == bankSlot) begin
						romBank1 <= wrData;
					end else begin
						scroll1 <= putScroll(scroll1, offset, wrData);
					end
				end
				// Only bit 0 picks the tile bank
				subBusPkg::tileBank: tileBank <= wrData[0];
				lth2: backColor <= wrData;
				default: ;
			endcase
		end
	end

endmodule

//--- logic/watchdogTimer.sv
`timescale 1ns/1ps

`include "subCpu_settings.svh"

module watchdogTimer import sysCtlPkg::*; (
	input  logic nVBLK,
	input  logic rstN,
	input  logic restart,
	input  logic running,
	output logic expired,
	output logic holdDone
);

	// Count values that end each phase
	localparam wdCount_t wdogLast = wdCount_t'(`WDOG_LIMIT);
	localparam wdCount_t holdLast = wdCount_t'(`RESET_HOLD - 1);

	wdCount_t  count;
	seqState_t phase;

	// Sequencer phase seen from the timer
	assign phase = running ? sRun : sHold;

	// One count per frame
	// Kicks and phase changes start it over
	always_ff @(posedge nVBLK or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else if (restart) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Too many frames since the last kick
	assign expired = (phase == sRun) && (count == wdogLast);

	// Last frame of the reset hold
	assign holdDone = (phase == sHold) && (count == holdLast);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the secondary CPU bus controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module subCpuCtlTb \
	-Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/VsubCpuCtlTb; then
	echo "Simulation run returned a failing status"
	exit 1
fi

exit 0

//--- tb/busModel.svh
`ifndef BUS_MODEL_SVH
`define BUS_MODEL_SVH

`include "subCpu_settings.svh"

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

logic [31:0] lfsrState = 32'hc7a4_8881;

// Fibonacci LFSR with taps 32 22 2 1
// One step per bit taken
function automatic logic [31:0] takeBits(input int n);
	logic [31:0] v;
	logic        fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		v = {v[30:0], fb};
	end
	return v;
endfunction

////////////////////////////////////////////////////////////////////////////
// Expected chip selects
////////////////////////////////////////////////////////////////////////////

// Bit order nScr0 nScr1 nObj nSnd nSPgm nMPgm nBufEn
function automatic logic [6:0] expectSelects(input logic [15:0] a, input logic w);
	logic [6:0] sel;
	sel = 7'h7f;
	if (a < 16'h2000) begin
		if (w) sel[6] = 1'b0;
	end else if (a < 16'h4000) begin
		if (w) sel[5] = 1'b0;
	end else if (a < 16'h4400) begin
		// Sound share RAM in both directions
		sel[3] = 1'b0;
	end else if (a < 16'h6000) begin
		if (w) sel[4] = 1'b0;
	end else if (a < 16'h8000) begin
		if (!w) sel[2] = 1'b0;
	end else if (!w) begin
		sel[1] = 1'b0;
	end
	// Buffer opens for the RAMs
	if (!sel[6] || !sel[5] || !sel[4] || !sel[3]) sel[0] = 1'b0;
	// And for both scroll latch groups
	if (w && a >= 16'h9000 && a < 16'h9800) sel[0] = 1'b0;
	return sel;
endfunction

`endif

//--- tb/subCpuCtlTb.sv
`timescale 1ns/1ps

`include "subCpu_settings.svh"

module subCpuCtlTb import subBusPkg::*, sysCtlPkg::*; ();

	logic       nVBLK;
	logic       rstN;
	logic       reqValid;
	subAddr_t   reqAddr;
	logic       reqWrite;
	subData_t   reqData;
	logic       reqReady;
	logic       nScr0, nScr1, nObj, nSnd, nSPgm, nMPgm, nBufEn;
	logic       nRes;
	logic       nIrq;
	scrollSet_t scroll0, scroll1;
	subData_t   romBank0, romBank1, backColor;
	logic       tileBank;

	// Expected DUT state
	logic       expRun;
	wdCount_t   expAge;
	logic       expNRes;
	logic       expNIrq;
	scrollSet_t expScroll0, expScroll1;
	subData_t   expBank0, expBank1, expBack;
	logic       expTile;

	`include "busModel.svh"

	subCpuCtl i_subCpuCtl (
		.nVBLK(nVBLK), .rstN(rstN),
		.reqValid(reqValid), .reqAddr(reqAddr), .reqWrite(reqWrite), .reqData(reqData),
		.reqReady(reqReady),
		.nScr0(nScr0), .nScr1(nScr1), .nObj(nObj), .nSnd(nSnd),
		.nSPgm(nSPgm), .nMPgm(nMPgm), .nBufEn(nBufEn),
		.nRes(nRes), .nIrq(nIrq),
		.scroll0(scroll0), .scroll1(scroll1),
		.romBank0(romBank0), .romBank1(romBank1),
		.tileBank(tileBank), .backColor(backColor)
	);

	initial begin
		nVBLK = 1'b0;
		forever #20 nVBLK = ~nVBLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure handling
	////////////////////////////////////////////////////////////////////////////

	task automatic stopOnFailure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		assert (exp === act) else begin
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
			stopOnFailure();
		end
	endtask

	// No select outside an accepted access
	assert property (@(posedge nVBLK) disable iff (!rstN)
		!(reqValid && reqReady) |-> (&{nScr0, nScr1, nObj, nSnd, nSPgm, nMPgm, nBufEn}))
		else begin
			$display("Chip select active without an accepted access at %0t", $time);
			stopOnFailure();
		end

	// Bus stalls exactly while the CPU sits in reset
	assert property (@(posedge nVBLK) disable iff (!rstN) reqReady == nRes)
		else begin
			$display("reqReady and nRes disagree at %0t", $time);
			stopOnFailure();
		end

	////////////////////////////////////////////////////////////////////////////
	// Model and stepping
	////////////////////////////////////////////////////////////////////////////

	task automatic clearModel();
		expScroll0 = '0;
		expScroll1 = '0;
		expBank0 = '0;
		expBank1 = '0;
		expBack = '0;
		expTile = 1'b0;
	endtask

	// Offset 3 is the bank and offset 7 is dead
	// The other offsets pack in order
	task automatic groupWrite(inout scrollSet_t s, inout subData_t bank,
			input logic [2:0] off, input subData_t d);
		case (off)
			3'd0, 3'd1, 3'd2: s[off*8 +: 8] = d;
			3'd3: bank = d;
			3'd4, 3'd5, 3'd6: s[(off - 3'd1)*8 +: 8] = d;
			default: ;
		endcase
	endtask

	task automatic modelEdge(input logic acc, input subAddr_t a, input logic w,
			input subData_t d);
		logic kicked;
		logic acked;
		kicked = acc && w && (a[15:10] == 6'b100000);
		acked = acc && w && (a[15:10] == 6'b100001);
		if (expRun) begin
			expNIrq = acked;
			if (expAge == `WDOG_LIMIT) begin
				// Expiry beats any write in this frame
				expRun = 1'b0;
				expAge = '0;
				expNRes = 1'b0;
				clearModel();
			end else begin
				expAge = kicked ? '0 : expAge + 1'b1;
				if (acc && w) begin
					case (a[15:10])
						6'b100100: groupWrite(expScroll0, expBank0, a[2:0], d);
						6'b100101: groupWrite(expScroll1, expBank1, a[2:0], d);
						6'b100010: expTile = d[0];
						6'b101000: expBack = d;
						default: ;
					endcase
				end
			end
		end else begin
			expNIrq = 1'b1;
			if (expAge == `RESET_HOLD - 1) begin
				expRun = 1'b1;
				expAge = '0;
				expNRes = 1'b1;
			end else begin
				expAge++;
			end
		end
	endtask

	task automatic checkOutputs();
		checkValue("nRes", expNRes, nRes);
		checkValue("nIrq", expNIrq, nIrq);
		checkValue("reqReady", expRun, reqReady);
		checkValue("scroll0", expScroll0, scroll0);
		checkValue("scroll1", expScroll1, scroll1);
		checkValue("romBank0", expBank0, romBank0);
		checkValue("romBank1", expBank1, romBank1);
		checkValue("tileBank", expTile, tileBank);
		checkValue("backColor", expBack, backColor);
	endtask

	// One frame checked right after the edge
	task automatic stepEdge();
		logic acc;
		acc = reqValid && expRun;
		@(posedge nVBLK);
		modelEdge(acc, reqAddr, reqWrite, reqData);
		@(negedge nVBLK);
		checkOutputs();
	endtask

	task automatic busAccess(input subAddr_t a, input logic w, input subData_t d);
		int waited;
		logic [6:0] sel;
		reqValid = 1'b1;
		reqAddr = a;
		reqWrite = w;
		reqData = d;
		waited = 0;
		while (!expRun) begin
			if (waited == 20) begin
				$display("Request to %h never accepted", a);
				stopOnFailure();
			end
			stepEdge();
			waited++;
		end
		#1;
		sel = expectSelects(a, w);
		checkValue("nScr0", sel[6], nScr0);
		checkValue("nScr1", sel[5], nScr1);
		checkValue("nObj", sel[4], nObj);
		checkValue("nSnd", sel[3], nSnd);
		checkValue("nSPgm", sel[2], nSPgm);
		checkValue("nMPgm", sel[1], nMPgm);
		checkValue("nBufEn", sel[0], nBufEn);
		stepEdge();
		reqValid = 1'b0;
	endtask

	// Kick before the timer gets close
	task automatic keepAlive();
		if (expRun && expAge >= `WDOG_LIMIT - 2) begin
			busAccess(`ADDR_WDOG, 1'b1, 8'h00);
		end
	endtask

	task automatic checkLatchesClear();
		checkValue("scroll0", 0, scroll0);
		checkValue("scroll1", 0, scroll1);
		checkValue("romBank0", 0, romBank0);
		checkValue("romBank1", 0, romBank1);
		checkValue("tileBank", 0, tileBank);
		checkValue("backColor", 0, backColor);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		subAddr_t    bases [12];
		int          sizes [12];
		logic [31:0] r;
		logic [31:0] d;
		int          cnt;
		int          lowCnt;
		logic        holding;
		bases = '{16'h0000, 16'h2000, 16'h4000, 16'h4400, 16'h6000, 16'h8000,
			16'h8400, 16'h8800, 16'h9000, 16'h9400, 16'hA000, 16'hC000};
		sizes = '{32'h2000, 32'h2000, 32'h0400, 32'h1C00, 32'h2000, 32'h0400,
			32'h0400, 32'h0400, 32'h0400, 32'h0400, 32'h0400, 32'h4000};
		rstN = 1'b0;
		reqValid = 1'b0;
		reqAddr = '0;
		reqWrite = 1'b0;
		reqData = '0;
		expRun = 1'b1;
		expAge = '0;
		expNRes = 1'b1;
		expNIrq = 1'b1;
		clearModel();
		repeat (10) @(negedge nVBLK);
		rstN = 1'b1;
		checkOutputs();

		// Interrupt comes up one frame after reset
		stepEdge();
		checkValue("nIrq", 0, nIrq);

		// Decode a fixed and a random address in each window
		for (int i = 0; i < 12; i++) begin
			for (int w = 0; w < 2; w++) begin
				keepAlive();
				d = takeBits(8);
				busAccess(bases[i], w[0], d[7:0]);
				keepAlive();
				r = takeBits(16);
				d = takeBits(8);
				busAccess(bases[i] + subAddr_t'(r % sizes[i]), w[0], d[7:0]);
			end
		end

		// Every offset of both latch groups
		for (int off = 0; off < 8; off++) begin
			keepAlive();
			d = takeBits(8);
			busAccess(16'h9000 + subAddr_t'(off), 1'b1, d[7:0]);
			keepAlive();
			d = takeBits(8);
			busAccess(16'h9400 + subAddr_t'(off), 1'b1, d[7:0]);
		end
		keepAlive();
		d = takeBits(8);
		busAccess(`ADDR_TBANK, 1'b1, d[7:0]);
		d = takeBits(8);
		busAccess(16'hA000, 1'b1, d[7:0]);

		// Acknowledge frees exactly one frame
		for (int i = 0; i < 3; i++) begin
			keepAlive();
			busAccess(`ADDR_IRQACK, 1'b1, 8'h00);
			checkValue("nIrq", 1, nIrq);
			stepEdge();
			checkValue("nIrq", 0, nIrq);
		end

		// Regular kicks keep the CPU running for at least 40 frames
		for (int i = 0; i < (40 + `WDOG_LIMIT - 2) / (`WDOG_LIMIT - 1); i++) begin
			busAccess(`ADDR_WDOG, 1'b1, 8'h00);
			repeat (`WDOG_LIMIT - 2) stepEdge();
			checkValue("nRes", 1, nRes);
			checkValue("reqReady", 1, reqReady);
		end

		// Last kick then let it expire
		busAccess(`ADDR_WDOG, 1'b1, 8'h00);
		cnt = 0;
		while (nRes) begin
			if (cnt > `WDOG_LIMIT + 5) begin
				$display("Watchdog never reset the CPU");
				stopOnFailure();
			end
			stepEdge();
			cnt++;
		end
		checkValue("frames to nRes low", `WDOG_LIMIT + 1, cnt);

		// Request waits out the hold
		// Nonzero byte so the late write shows on backColor
		d = takeBits(8) | 32'h1;
		reqValid = 1'b1;
		reqAddr = 16'hA000;
		reqWrite = 1'b1;
		reqData = d[7:0];
		lowCnt = 1;
		holding = 1'b1;
		while (holding) begin
			if (lowCnt > `RESET_HOLD + 5) begin
				$display("Reset hold never ended");
				stopOnFailure();
			end
			checkValue("reqReady", 0, reqReady);
			checkLatchesClear();
			stepEdge();
			if (nRes) begin
				holding = 1'b0;
			end else begin
				lowCnt++;
			end
		end
		checkValue("nRes low frames", `RESET_HOLD, lowCnt);
		checkValue("backColor", 0, backColor);
		checkValue("reqReady", 1, reqReady);
		stepEdge();
		reqValid = 1'b0;
		checkValue("backColor", d[7:0], backColor);

		$display("Simulation passed");
		$finish;
	end

endmodule
